// File: compile.f
+incdir+src
src/len5_mem_pkg.sv
src/ldst_dispatch.sv
src/mshr_entry.sv
src/l2_arbiter_wb.sv
src/cu_dp_mem.sv
sim/l2_mem_model.sv
sim/tb_cu_dp_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator; the exit status is the verdict
cd "$(dirname "$0")" && \
	verilator --binary --timing -Wno-fatal -f compile.f \
		--top-module tb_cu_dp_mem -o tb_cu_dp_mem && \
	./obj_dir/tb_cu_dp_mem || exit 1

// File: sim/tb_cu_dp_mem.sv
`include "len5_mem_consts.svh"

module tb_cu_dp_mem;

	timeunit 1ns;
	timeprecision 1ps;

	import len5_mem_pkg::*;

	// 14 directed, 10 burst, 40 random, 3 flushed, 6 after the flush
	localparam int NUM_OPS   = 73;
	localparam int CYC_LIMIT = 40 * NUM_OPS + 200;

	logic      clk_i;
	logic      arst_n_i;
	logic      flush_i;
	mem_ins_t  ins_i;
	logic      ins_valid_i;
	logic      stall_o;
	l2_req_t   l2_req_o;
	logic      l2_req_valid_o;
	logic      l2_req_rdy_i;
	l2_ans_t   l2_ans_i;
	logic      l2_ans_valid_i;
	logic      l2_ans_rdy_o;
	wb_t       wb_o;
	logic      wb_valid_o;
	logic      wb_rdy_i;

	// Scoreboard by tag, expected L2 requests by word
	wb_t              exp_wb [16];
	logic             pending [16];
	mem_ins_t         req_ins [64];
	logic             req_pend [64];
	logic [`XLEN-1:0] shadow [64];
	// Slots with an accepted L2 request and no answer yet
	logic             ans_waiting [`NUM_MSHR];
	integer           seed;
	// Writeback ready draws
	integer           rdy_seed;
	int               cycles;
	int               outstanding;
	int               max_outstanding;
	logic             wb_hold;
	logic [3:0]       next_tag;

	cu_dp_mem cu_dp_mem_inst (
		.clk_i, .arst_n_i, .flush_i, .ins_i, .ins_valid_i, .stall_o,
		.l2_req_o, .l2_req_valid_o, .l2_req_rdy_i,
		.l2_ans_i, .l2_ans_valid_i, .l2_ans_rdy_o,
		.wb_o, .wb_valid_o, .wb_rdy_i
	);

	l2_mem_model u_l2_mem_model (
		.clk_i, .arst_n_i,
		.req_i       (l2_req_o),
		.req_valid_i (l2_req_valid_o),
		.req_rdy_o   (l2_req_rdy_i),
		.ans_o       (l2_ans_i),
		.ans_valid_o (l2_ans_valid_i),
		.ans_rdy_i   (l2_ans_rdy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got !== exp) begin
			fail($sformatf("MISMATCH wb_o: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_l2_req(input l2_req_t got, input l2_req_t exp);
		if (got !== exp) begin
			fail($sformatf("MISMATCH l2_req_o: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_ans_rdy(input logic got, input logic exp);
		if (got !== exp) begin
			fail($sformatf("MISMATCH l2_ans_rdy_o: got %h expected %h", got, exp));
		end
	endtask

	function automatic logic is_misaligned(input mem_ins_t ins);
		case (ins.op)
			LH, LHU, SH: return ins.addr[0];
			LW, SW:      return ins.addr[1:0] != 2'b00;
			default:     return 1'b0;
		endcase
	endfunction

	// Expected writeback from the op and the word it reads
	function automatic wb_t ref_result(input mem_ins_t ins, input logic [`XLEN-1:0] word);
		wb_t        r;
		int         off;
		logic [7:0] b;
		logic [15:0] h;
		off = ins.addr[1:0];
		b = word[8*off +: 8];
		h = word[8*(off & 2) +: 16];
		r.tag = ins.tag;
		r.data = '0;
		r.is_store = ins.op inside {SB, SH, SW};
		r.except_code = E_NONE;
		if (is_misaligned(ins)) begin
			r.except_code = r.is_store ? E_ST_MISALIGNED : E_LD_MISALIGNED;
			return r;
		end
		case (ins.op)
			LB:  r.data = {{24{b[7]}}, b};
			LBU: r.data = {24'h0, b};
			LH:  r.data = {{16{h[15]}}, h};
			LHU: r.data = {16'h0, h};
			LW:  r.data = word;
			default: r.data = '0;
		endcase
		return r;
	endfunction

	// Byte lanes a store touches, with its data placed in them
	function automatic l2_req_t ref_l2_req(input mem_ins_t ins, input logic [1:0] id);
		l2_req_t r;
		int      off;
		off = ins.addr[1:0];
		r.id = id;
		r.is_store = ins.op inside {SB, SH, SW};
		r.waddr = ins.addr[`XLEN-1:2];
		r.mask = '0;
		r.wdata = '0;
		case (ins.op)
			SB: begin
				r.mask[off] = 1'b1;
				r.wdata[8*off +: 8] = ins.wdata[7:0];
			end
			SH: begin
				r.mask[off +: 2] = 2'b11;
				r.wdata[8*off +: 16] = ins.wdata[15:0];
			end
			SW: begin
				r.mask = 4'hf;
				r.wdata = ins.wdata;
			end
			default: ;
		endcase
		return r;
	endfunction

	function automatic logic [`XLEN-1:0] merge_store(input logic [`XLEN-1:0] word,
			input mem_ins_t ins);
		l2_req_t r;
		r = ref_l2_req(ins, 2'd0);
		for (int i = 0; i < 4; i++) begin
			if (r.mask[i]) word[8*i +: 8] = r.wdata[8*i +: 8];
		end
		return word;
	endfunction

	// Present one op until accepted, and log what it should do
	task automatic issue(input ldst_op_e op, input logic [7:0] addr, input logic [31:0] wdata);
		mem_ins_t ins;
		ins.op = op;
		ins.addr = {24'h0, addr};
		ins.wdata = wdata;
		ins.tag = next_tag;
		next_tag = next_tag + 1'b1;
		while (pending[ins.tag]) @(negedge clk_i);
		@(posedge clk_i);
		ins_i <= ins;
		ins_valid_i <= 1'b1;
		forever begin
			@(negedge clk_i);
			if (!stall_o) break;
		end
		pending[ins.tag] = 1'b1;
		exp_wb[ins.tag] = ref_result(ins, shadow[addr[7:2]]);
		if (!is_misaligned(ins)) begin
			req_ins[addr[7:2]] = ins;
			req_pend[addr[7:2]] = 1'b1;
			if (ins.op inside {SB, SH, SW}) shadow[addr[7:2]] = merge_store(shadow[addr[7:2]], ins);
		end
		@(posedge clk_i);
		ins_valid_i <= 1'b0;
	endtask

	task automatic issue_random();
		ldst_op_e    op;
		logic [7:0]  addr;
		op = ldst_op_e'({$random(seed)} % 8);
		addr = {$random(seed)} % 256;
		// Mostly aligned, some misaligned
		if (({$random(seed)} % 8) != 0) begin
			if (op inside {LH, LHU, SH}) addr[0] = 1'b0;
			if (op inside {LW, SW}) addr[1:0] = 2'b00;
		end
		issue(op, addr, $random(seed));
	endtask

	task automatic drain();
		int busy;
		do begin
			@(negedge clk_i);
			busy = 0;
			for (int t = 0; t < 16; t++) busy += pending[t];
		end while (busy != 0);
	endtask

	// Writeback and L2 port monitor
	always @(negedge clk_i) begin
		if (wb_valid_o && wb_rdy_i) begin
			if (!pending[wb_o.tag]) fail($sformatf("writeback for tag %h not pending", wb_o.tag));
			check_wb(wb_o, exp_wb[wb_o.tag]);
			pending[wb_o.tag] = 1'b0;
		end
		// A slot takes its answer only while waiting for it
		if (l2_ans_valid_i) check_ans_rdy(l2_ans_rdy_o, ans_waiting[l2_ans_i.id]);
		if (l2_req_valid_o && l2_req_rdy_i) begin
			if (!req_pend[l2_req_o.waddr[5:0]]) fail("L2 request without a matching operation");
			if (ans_waiting[l2_req_o.id]) begin
				fail("L2 request from a slot still waiting for an answer");
			end
			check_l2_req(l2_req_o, ref_l2_req(req_ins[l2_req_o.waddr[5:0]], l2_req_o.id));
			req_pend[l2_req_o.waddr[5:0]] = 1'b0;
			ans_waiting[l2_req_o.id] = 1'b1;
			outstanding++;
		end
		if (l2_ans_valid_i && l2_ans_rdy_o) begin
			ans_waiting[l2_ans_i.id] = 1'b0;
			outstanding--;
		end
		if (outstanding > max_outstanding) max_outstanding = outstanding;
	end

	always @(posedge clk_i) begin
		wb_rdy_i <= wb_hold ? 1'b0 : (({$random(rdy_seed)} % 4) != 0);
		cycles++;
		if (cycles > CYC_LIMIT) fail("timeout, the DUT stopped making progress");
	end

	initial begin
		seed = 32'hb10a;
		rdy_seed = 32'hb10a;
		arst_n_i = 1'b0;
		flush_i = 1'b0;
		ins_i = '0;
		ins_valid_i = 1'b0;
		wb_rdy_i = 1'b0;
		wb_hold = 1'b0;
		next_tag = '0;
		cycles = 0;
		outstanding = 0;
		max_outstanding = 0;
		for (int i = 0; i < 64; i++) begin
			shadow[i] = 32'h5a00_0000 ^ (i * 32'h0101_0107);
			req_pend[i] = 1'b0;
		end
		for (int t = 0; t < 16; t++) pending[t] = 1'b0;
		for (int s = 0; s < `NUM_MSHR; s++) ans_waiting[s] = 1'b0;
		repeat (3) @(posedge clk_i);
		arst_n_i <= 1'b1;
		@(negedge clk_i);
		if (stall_o || l2_req_valid_o || wb_valid_o) fail("outputs not idle after reset");

		// Every store width, then every load width on the words written
		issue(SW, 8'h20, 32'h8765_4321);
		issue(SH, 8'h26, 32'h0000_f00d);
		issue(SB, 8'h23, 32'h0000_00a5);
		issue(LB, 8'h23, '0);
		issue(LBU, 8'h23, '0);
		issue(LH, 8'h22, '0);
		issue(LHU, 8'h26, '0);
		issue(LW, 8'h20, '0);
		issue(LB, 8'h21, '0);
		// Misaligned ops
		issue(LH, 8'h41, '0);
		issue(LHU, 8'h43, '0);
		issue(LW, 8'h42, '0);
		issue(SH, 8'h45, 32'h1234);
		issue(SW, 8'h47, 32'h55aa_55aa);
		drain();

		// Burst to distinct words
		for (int i = 0; i < 10; i++) issue(LW, 8'h80 + 8'(4 * i), '0);
		drain();

		for (int i = 0; i < 40; i++) issue_random();
		drain();

		// Loads parked, then flushed away
		wb_hold = 1'b1;
		issue(LW, 8'hc0, '0);
		issue(LBU, 8'hc5, '0);
		issue(LH, 8'hca, '0);
		do @(negedge clk_i); while (l2_req_valid_o);
		@(posedge clk_i);
		flush_i <= 1'b1;
		@(posedge clk_i);
		flush_i <= 1'b0;
		for (int t = 0; t < 16; t++) pending[t] = 1'b0;
		for (int i = 0; i < 64; i++) req_pend[i] = 1'b0;
		wb_hold <= 1'b0;
		repeat (2) @(posedge clk_i);
		for (int i = 0; i < 6; i++) issue_random();
		drain();

		if (max_outstanding < 2) begin
			fail("never more than one L2 request outstanding");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: sim/l2_mem_model.sv
`include "len5_mem_consts.svh"

module l2_mem_model (
	input  logic                     clk_i,
	input  logic                     arst_n_i,

	// Request side
	input  len5_mem_pkg::l2_req_t    req_i,
	input  logic                     req_valid_i,
	output logic                     req_rdy_o,

	// Answer side
	output len5_mem_pkg::l2_ans_t    ans_o,
	output logic                     ans_valid_o,
	input  logic                     ans_rdy_i
);

	timeunit 1ns;
	timeprecision 1ps;

	import len5_mem_pkg::*;

	logic [`XLEN-1:0]          mem [64];
	logic [`MSHR_IDX_LEN-1:0]  q_id [$];
	logic [`XLEN-1:0]          q_data [$];
	int                        q_due [$];
	int                        cyc;
	integer                    seed;

	// Pattern spread over the whole word index
	initial begin
		seed = 32'hb10a;
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'h5a00_0000 ^ (i * 32'h0101_0107);
		end
	end

	always @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_rdy_o   <= 1'b0;
			ans_valid_o <= 1'b0;
			ans_o       <= '0;
			cyc         = 0;
		end else begin
			cyc = cyc + 1;
			// Retire the presented answer, or present the next one once due
			if (ans_valid_o && ans_rdy_i) begin
				void'(q_id.pop_front());
				void'(q_data.pop_front());
				void'(q_due.pop_front());
				ans_valid_o <= 1'b0;
			end else if (!ans_valid_o && q_id.size() > 0 && cyc >= q_due[0]) begin
				ans_o.id    <= q_id[0];
				ans_o.rdata <= q_data[0];
				ans_valid_o <= 1'b1;
			end
			// Accept a request; stores write through the byte mask
			if (req_valid_i && req_rdy_o) begin
				if (req_i.is_store) begin
					for (int b = 0; b < `BE_LEN; b++) begin
						if (req_i.mask[b]) mem[req_i.waddr[5:0]][8*b +: 8] = req_i.wdata[8*b +: 8];
					end
				end
				q_id.push_back(req_i.id);
				q_data.push_back(mem[req_i.waddr[5:0]]);
				q_due.push_back(cyc + 1 + ({$random(seed)} % 6));
			end
			// Ready drops about one cycle in four
			req_rdy_o <= ({$random(seed)} % 4) != 0;
		end
	end

endmodule

// File: src/cu_dp_mem.sv
`include "len5_mem_consts.svh"

module cu_dp_mem (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     flush_i,

	// Operations from the control side
	input  len5_mem_pkg::mem_ins_t   ins_i,
	input  logic                     ins_valid_i,
	output logic                     stall_o,

	// L2 request port
	output len5_mem_pkg::l2_req_t    l2_req_o,
	output logic                     l2_req_valid_o,
	input  logic                     l2_req_rdy_i,

	// L2 answer port
	input  len5_mem_pkg::l2_ans_t    l2_ans_i,
	input  logic                     l2_ans_valid_i,
	output logic                     l2_ans_rdy_o,

	// Writeback port
	output len5_mem_pkg::wb_t        wb_o,
	output logic                     wb_valid_o,
	input  logic                     wb_rdy_i
);

	import len5_mem_pkg::*;

	// Slot status and payloads
	mshr_state_e                slot_state [`NUM_MSHR];
	logic [`WADDR_LEN-1:0]      slot_addr [`NUM_MSHR];
	logic [`NUM_MSHR-1:0]       slot_req_valid;
	l2_req_t                    slot_req [`NUM_MSHR];
	logic [`NUM_MSHR-1:0]       slot_res_valid;
	wb_t                        slot_res [`NUM_MSHR];

	// Dispatch and arbiter controls
	logic [`NUM_MSHR-1:0]       alloc;
	mem_ins_t                   ins_dec;
	logic [`NUM_MSHR-1:0]       req_grant;
	logic [`NUM_MSHR-1:0]       ans_valid;
	logic [`XLEN-1:0]           ans_rdata;
	logic [`NUM_MSHR-1:0]       wb_grant;
	logic                       exc_valid;
	wb_t                        exc;
	logic                       exc_grant;

	// Decode, alignment, allocation
	ldst_dispatch u_ldst_dispatch (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.flush_i      (flush_i),
		.ins_i        (ins_i),
		.ins_valid_i  (ins_valid_i),
		.slot_state_i (slot_state),
		.slot_addr_i  (slot_addr),
		.exc_grant_i  (exc_grant),
		.stall_o      (stall_o),
		.alloc_o      (alloc),
		.ins_o        (ins_dec),
		.exc_valid_o  (exc_valid),
		.exc_o        (exc)
	);

	// Miss-status holding slots
	for (genvar i = 0; i < `NUM_MSHR; i++) begin : gen_mshr
		mshr_entry #(
			.MSHR_ID (`MSHR_IDX_LEN'(i))
		) u_mshr_entry (
			.clk_i       (clk_i),
			.arst_n_i    (arst_n_i),
			.flush_i     (flush_i),
			.alloc_i     (alloc[i]),
			.ins_i       (ins_dec),
			.req_grant_i (req_grant[i]),
			.ans_valid_i (ans_valid[i]),
			.ans_rdata_i (ans_rdata),
			.wb_grant_i  (wb_grant[i]),
			.state_o     (slot_state[i]),
			.addr_o      (slot_addr[i]),
			.req_valid_o (slot_req_valid[i]),
			.req_o       (slot_req[i]),
			.res_valid_o (slot_res_valid[i]),
			.res_o       (slot_res[i])
		);
	end

	// L2 arbitration and writeback select
	l2_arbiter_wb u_l2_arbiter_wb (
		.clk_i            (clk_i),
		.arst_n_i         (arst_n_i),
		.slot_req_valid_i (slot_req_valid),
		.slot_req_i       (slot_req),
		.slot_res_valid_i (slot_res_valid),
		.slot_res_i       (slot_res),
		.slot_state_i     (slot_state),
		.exc_valid_i      (exc_valid),
		.exc_i            (exc),
		.l2_req_rdy_i     (l2_req_rdy_i),
		.l2_ans_valid_i   (l2_ans_valid_i),
		.l2_ans_i         (l2_ans_i),
		.wb_rdy_i         (wb_rdy_i),
		.req_grant_o      (req_grant),
		.ans_valid_o      (ans_valid),
		.ans_rdata_o      (ans_rdata),
		.wb_grant_o       (wb_grant),
		.exc_grant_o      (exc_grant),
		.l2_req_valid_o   (l2_req_valid_o),
		.l2_req_o         (l2_req_o),
		.l2_ans_rdy_o     (l2_ans_rdy_o),
		.wb_valid_o       (wb_valid_o),
		.wb_o             (wb_o)
	);

endmodule

// File: src/l2_arbiter_wb.sv
`include "len5_mem_consts.svh"

module l2_arbiter_wb (
	input  logic                        clk_i,
	input  logic                        arst_n_i,

	// From the slots
	input  logic [`NUM_MSHR-1:0]        slot_req_valid_i,
	input  len5_mem_pkg::l2_req_t       slot_req_i [`NUM_MSHR],
	input  logic [`NUM_MSHR-1:0]        slot_res_valid_i,
	input  len5_mem_pkg::wb_t           slot_res_i [`NUM_MSHR],
	input  len5_mem_pkg::mshr_state_e   slot_state_i [`NUM_MSHR],

	// Exception result from dispatch
	input  logic                        exc_valid_i,
	input  len5_mem_pkg::wb_t           exc_i,

	// Port handshakes
	input  logic                        l2_req_rdy_i,
	input  logic                        l2_ans_valid_i,
	input  len5_mem_pkg::l2_ans_t       l2_ans_i,
	input  logic                        wb_rdy_i,

	// Back to the slots and dispatch
	output logic [`NUM_MSHR-1:0]        req_grant_o,
	output logic [`NUM_MSHR-1:0]        ans_valid_o,
	output logic [`XLEN-1:0]            ans_rdata_o,
	output logic [`NUM_MSHR-1:0]        wb_grant_o,
	output logic                        exc_grant_o,

	output logic                        l2_req_valid_o,
	output len5_mem_pkg::l2_req_t       l2_req_o,
	output logic                        l2_ans_rdy_o,

	output logic                        wb_valid_o,
	output len5_mem_pkg::wb_t           wb_o
);

	import len5_mem_pkg::*;

	logic [`MSHR_IDX_LEN-1:0]  ptr_q;
	logic [`MSHR_IDX_LEN-1:0]  cand;
	logic [`MSHR_IDX_LEN-1:0]  req_idx;
	logic                      req_any;
	logic                      res_any;
	logic [`MSHR_IDX_LEN-1:0]  prio_idx;
	logic [`MSHR_IDX_LEN-1:0]  wb_idx;
	logic                      use_exc;
	logic                      hold_q;
	logic                      hold_exc_q;
	logic [`MSHR_IDX_LEN-1:0]  hold_idx_q;

	// Round-robin search, nearest to the pointer wins
	always_comb begin
		req_any = 1'b0;
		req_idx = ptr_q;
		cand    = ptr_q;
		for (int k = `NUM_MSHR - 1; k >= 0; k--) begin
			cand = ptr_q + `MSHR_IDX_LEN'(k);
			if (slot_req_valid_i[cand]) begin
				req_any = 1'b1;
				req_idx = cand;
			end
		end
	end

	// Pointer parks on a stalled request, steps past a granted one
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ptr_q <= '0;
		end else if (req_any) begin
			ptr_q <= l2_req_rdy_i ? req_idx + 1'b1 : req_idx;
		end
	end

	assign l2_req_valid_o = req_any;
	assign l2_req_o       = slot_req_i[req_idx];

	always_comb begin
		req_grant_o = '0;
		req_grant_o[req_idx] = req_any & l2_req_rdy_i;
	end

	// Answers go to the slot named by id
	assign l2_ans_rdy_o = slot_state_i[l2_ans_i.id] inside {S_WAIT, S_DISCARD};
	assign ans_rdata_o  = l2_ans_i.rdata;

	always_comb begin
		ans_valid_o = '0;
		ans_valid_o[l2_ans_i.id] = l2_ans_valid_i & l2_ans_rdy_o;
	end

	// Fixed priority, lowest slot first
	always_comb begin
		res_any  = |slot_res_valid_i;
		prio_idx = '0;
		for (int i = `NUM_MSHR - 1; i >= 0; i--) begin
			if (slot_res_valid_i[i]) prio_idx = `MSHR_IDX_LEN'(i);
		end
	end

	// Stalled writeback keeps its source, else exception first
	always_comb begin
		if (hold_q && hold_exc_q && exc_valid_i) begin
			use_exc = 1'b1;
			wb_idx  = prio_idx;
		end else if (hold_q && !hold_exc_q && slot_res_valid_i[hold_idx_q]) begin
			use_exc = 1'b0;
			wb_idx  = hold_idx_q;
		end else begin
			use_exc = exc_valid_i;
			wb_idx  = prio_idx;
		end
	end

	assign wb_valid_o  = exc_valid_i | res_any;
	assign wb_o        = use_exc ? exc_i : slot_res_i[wb_idx];
	assign exc_grant_o = use_exc & wb_rdy_i;

	always_comb begin
		wb_grant_o = '0;
		wb_grant_o[wb_idx] = ~use_exc & res_any & wb_rdy_i;
	end

	// Remember which source is waiting on wb_rdy_i
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_q     <= 1'b0;
			hold_exc_q <= 1'b0;
			hold_idx_q <= '0;
		end else begin
			hold_q     <= wb_valid_o & ~wb_rdy_i;
			hold_exc_q <= use_exc;
			hold_idx_q <= wb_idx;
		end
	end

endmodule

// File: src/mshr_entry.sv
`include "len5_mem_consts.svh"

module mshr_entry #(
	parameter logic [`MSHR_IDX_LEN-1:0] MSHR_ID = '0
) (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        flush_i,

	// Allocation from dispatch
	input  logic                        alloc_i,
	input  len5_mem_pkg::mem_ins_t      ins_i,

	// From the arbiter
	input  logic                        req_grant_i,
	input  logic                        ans_valid_i,
	input  logic [`XLEN-1:0]            ans_rdata_i,
	input  logic                        wb_grant_i,

	// Status back to dispatch
	output len5_mem_pkg::mshr_state_e   state_o,
	output logic [`WADDR_LEN-1:0]       addr_o,

	output logic                        req_valid_o,
	output len5_mem_pkg::l2_req_t       req_o,
	output logic                        res_valid_o,
	output len5_mem_pkg::wb_t           res_o
);

	import len5_mem_pkg::*;

	mshr_state_e          state_q;
	mshr_state_e          state_d;
	mem_ins_t             ins_q;
	logic [`XLEN-1:0]     rdata_q;
	logic                 is_store;
	logic [4:0]           bit_off;
	logic [`XLEN-1:0]     rdata_sh;
	logic [`XLEN-1:0]     ld_data;
	logic [`BE_LEN-1:0]   st_mask;
	logic [`XLEN-1:0]     st_data;

	// Slot FSM
	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE:    if (alloc_i) state_d = S_REQ;
			S_REQ: begin
				if (flush_i) state_d = S_IDLE;
				else if (req_grant_i) state_d = S_WAIT;
			end
			// Answer in the flush cycle is simply dropped
			S_WAIT: begin
				if (ans_valid_i) state_d = flush_i ? S_IDLE : S_DONE;
				else if (flush_i) state_d = S_DISCARD;
			end
			S_DISCARD: if (ans_valid_i) state_d = S_IDLE;
			S_DONE:    if (flush_i || wb_grant_i) state_d = S_IDLE;
			default:   state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Operation payload
	always_ff @(posedge clk_i) begin
		if (alloc_i && state_q == S_IDLE) begin
			ins_q <= ins_i;
		end
	end

	// Answered word
	always_ff @(posedge clk_i) begin
		if (ans_valid_i && state_q == S_WAIT) begin
			rdata_q <= ans_rdata_i;
		end
	end

	assign is_store = ins_q.op inside {SB, SH, SW};
	assign bit_off  = {ins_q.addr[1:0], 3'b000};

	// Store lane placement
	always_comb begin
		st_mask = '0;
		st_data = '0;
		case (ins_q.op)
			SB: begin
				st_mask = `BE_LEN'(1) << ins_q.addr[1:0];
				st_data = {{(`XLEN-8){1'b0}}, ins_q.wdata[7:0]} << bit_off;
			end
			SH: begin
				st_mask = `BE_LEN'(3) << ins_q.addr[1:0];
				st_data = {{(`XLEN-16){1'b0}}, ins_q.wdata[15:0]} << bit_off;
			end
			SW: begin
				st_mask = '1;
				st_data = ins_q.wdata;
			end
			default: ;
		endcase
	end

	// Load lane select and extension
	always_comb begin
		rdata_sh = rdata_q >> bit_off;
		case (ins_q.op)
			LB:      ld_data = {{(`XLEN-8){rdata_sh[7]}}, rdata_sh[7:0]};
			LBU:     ld_data = {{(`XLEN-8){1'b0}}, rdata_sh[7:0]};
			LH:      ld_data = {{(`XLEN-16){rdata_sh[15]}}, rdata_sh[15:0]};
			LHU:     ld_data = {{(`XLEN-16){1'b0}}, rdata_sh[15:0]};
			LW:      ld_data = rdata_sh;
			// stores return no data
			default: ld_data = '0;
		endcase
	end

	assign state_o = state_q;
	assign addr_o  = ins_q.addr[`XLEN-1:2];

	// L2 request, loads carry an empty mask
	assign req_valid_o    = (state_q == S_REQ);
	assign req_o.id       = MSHR_ID;
	assign req_o.is_store = is_store;
	assign req_o.waddr    = ins_q.addr[`XLEN-1:2];
	assign req_o.wdata    = st_data;
	assign req_o.mask     = st_mask;

	// Result
	assign res_valid_o       = (state_q == S_DONE);
	assign res_o.tag         = ins_q.tag;
	assign res_o.data        = ld_data;
	assign res_o.is_store    = is_store;
	assign res_o.except_code = E_NONE;

endmodule

// File: src/ldst_dispatch.sv
`include "len5_mem_consts.svh"

module ldst_dispatch (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        flush_i,

	// Operation from the control side
	input  len5_mem_pkg::mem_ins_t      ins_i,
	input  logic                        ins_valid_i,

	// Slot status
	input  len5_mem_pkg::mshr_state_e   slot_state_i [`NUM_MSHR],
	input  logic [`WADDR_LEN-1:0]       slot_addr_i [`NUM_MSHR],

	// Exception result taken by writeback
	input  logic                        exc_grant_i,

	output logic                        stall_o,
	output logic [`NUM_MSHR-1:0]        alloc_o,
	output len5_mem_pkg::mem_ins_t      ins_o,
	output logic                        exc_valid_o,
	output len5_mem_pkg::wb_t           exc_o
);

	import len5_mem_pkg::*;

	logic                      is_store;
	logic                      misaligned;
	logic                      any_free;
	logic [`MSHR_IDX_LEN-1:0]  free_idx;
	logic                      conflict;
	logic                      accept;
	logic                      exc_valid_q;
	wb_t                       exc_q;

	// Decode and natural alignment check
	always_comb begin
		is_store   = ins_i.op inside {SB, SH, SW};
		misaligned = 1'b0;
		case (ins_i.op)
			LH, LHU, SH: misaligned = ins_i.addr[0];
			LW, SW:      misaligned = |ins_i.addr[1:0];
			default:     misaligned = 1'b0;
		endcase
	end

	// Lowest free slot, and word conflicts with busy slots
	always_comb begin
		any_free = 1'b0;
		free_idx = '0;
		conflict = 1'b0;
		for (int i = `NUM_MSHR - 1; i >= 0; i--) begin
			if (slot_state_i[i] == S_IDLE) begin
				any_free = 1'b1;
				free_idx = `MSHR_IDX_LEN'(i);
			end else if (slot_addr_i[i] == ins_i.addr[`XLEN-1:2]) begin
				conflict = 1'b1;
			end
		end
	end

	// Same-word ops wait so they complete in order
	assign stall_o = ~any_free | (ins_valid_i & conflict) | exc_valid_q;

	// Nothing enters during a flush
	assign accept = ins_valid_i & ~stall_o & ~flush_i;

	// One-hot allocation, legal ops only
	always_comb begin
		alloc_o = '0;
		if (accept && !misaligned) begin
			alloc_o[free_idx] = 1'b1;
		end
	end

	// Slots capture the op as presented
	assign ins_o = ins_i;

	// Held exception result
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exc_valid_q <= 1'b0;
		end else if (flush_i) begin
			exc_valid_q <= 1'b0;
		end else if (accept && misaligned) begin
			exc_valid_q <= 1'b1;
		end else if (exc_grant_i) begin
			exc_valid_q <= 1'b0;
		end
	end

	// Exception payload, loaded with the valid bit
	always_ff @(posedge clk_i) begin
		if (accept && misaligned) begin
			exc_q.tag         <= ins_i.tag;
			exc_q.data        <= '0;
			exc_q.is_store    <= is_store;
			exc_q.except_code <= is_store ? E_ST_MISALIGNED : E_LD_MISALIGNED;
		end
	end

	assign exc_valid_o = exc_valid_q;
	assign exc_o       = exc_q;

endmodule

// File: src/len5_mem_pkg.sv
`include "len5_mem_consts.svh"

package len5_mem_pkg;

	// Load/store opcodes, loads before stores
	typedef enum logic [2:0] {
		LB,
		LBU,
		LH,
		LHU,
		LW,
		SB,
		SH,
		SW
	} ldst_op_e;

	// Exception codes reported on writeback
	typedef enum logic [1:0] {
		E_NONE,
		E_LD_MISALIGNED,
		E_ST_MISALIGNED
	} except_code_e;

	// Slot FSM states
	typedef enum logic [2:0] {
		S_IDLE,
		S_REQ,
		S_WAIT,
		S_DISCARD,
		S_DONE
	} mshr_state_e;

	// Operation from the control side
	typedef struct packed {
		ldst_op_e             op;
		logic [`XLEN-1:0]     addr;
		logic [`XLEN-1:0]     wdata;
		logic [`TAG_LEN-1:0]  tag;
	} mem_ins_t;

	// Request towards L2, word granular
	typedef struct packed {
		logic [`MSHR_IDX_LEN-1:0] id;
		logic                     is_store;
		logic [`WADDR_LEN-1:0]    waddr;
		logic [`XLEN-1:0]         wdata;
		logic [`BE_LEN-1:0]       mask;
	} l2_req_t;

	// Answer from L2, routed back by id
	typedef struct packed {
		logic [`MSHR_IDX_LEN-1:0] id;
		logic [`XLEN-1:0]         rdata;
	} l2_ans_t;

	// Result on the writeback port
	typedef struct packed {
		logic [`TAG_LEN-1:0] tag;
		logic [`XLEN-1:0]    data;
		logic                is_store;
		except_code_e        except_code;
	} wb_t;

endpackage

// File: src/len5_mem_consts.svh
`ifndef LEN5_MEM_CONSTS_SVH
`define LEN5_MEM_CONSTS_SVH

// Data and address width
`define XLEN 32

// Word address, byte offset stripped
`define WADDR_LEN (`XLEN - 2)

// One enable bit per byte of a word
`define BE_LEN 4

// Destination tag carried by each operation
`define TAG_LEN 4

// Miss-status holding slots
`define NUM_MSHR 4

// Slot index, also the L2 request/answer id
`define MSHR_IDX_LEN 2

`endif
